// ==== verilog/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// first fetch after reset.
`define MIPS_RESET_PC 32'h0000_0004

// jr to this address stops the core.
`define MIPS_HALT_PC 32'h0000_0000

// general purpose register count.
`define MIPS_NUM_REGS 32

// register read out as register_v0.
`define MIPS_V0_REG 2

`endif

// ==== verilog/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    // major opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL instructions.
    typedef enum logic [5:0] {
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // two views of one fetched word.
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef struct packed {
        alu_op_e op;
        logic    use_imm;  // immediate replaces b.
        logic    sign_ext; // else zero extend.
    } alu_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/avalon_pkg.sv ====
`default_nettype none

package avalon_pkg;

    // master to slave.
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
    } av_req_t;

    // slave to master.
    typedef struct packed {
        logic [31:0] readdata;
        logic        waitrequest;
    } av_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
    input  mips_isa_pkg::alu_ctrl_t ctrl,
    input  logic [31:0]             a,
    input  logic [31:0]             b,
    input  logic [15:0]             imm,
    output logic [31:0]             result
);

    logic [31:0] imm_ext;
    logic [31:0] opb;

    // sign extend for addiu and offsets, zero extend for ori.
    assign imm_ext = ctrl.sign_ext ? {{16{imm[15]}}, imm} : {16'd0, imm};
    assign opb     = ctrl.use_imm ? imm_ext : b;

    always_comb begin
        case (ctrl.op)
            mips_isa_pkg::ALU_ADD:  result = a + opb;
            mips_isa_pkg::ALU_SUB:  result = a - opb;
            mips_isa_pkg::ALU_AND:  result = a & opb;
            mips_isa_pkg::ALU_OR:   result = a | opb;
            mips_isa_pkg::ALU_XOR:  result = a ^ opb;
            mips_isa_pkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(opb)};
            mips_isa_pkg::ALU_SLTU: result = {31'd0, a < opb};
            default:                result = a + opb;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_settings.svh"

module mips_regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [4:0]  wr_addr,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] register_v0
);

    logic [31:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data; // $zero never written.
        end
    end

    // combinational read ports.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    assign register_v0 = regs[`MIPS_V0_REG];

endmodule

`default_nettype wire

// ==== verilog/mips_bus_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_bus_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic                 write,
    input  logic [31:0]          addr,
    input  logic [31:0]          wdata,
    output logic                 done,
    output logic [31:0]          rdata,
    output avalon_pkg::av_req_t  av_req,
    input  avalon_pkg::av_rsp_t  av_rsp
);

    logic        rd_q;
    logic        wr_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic        busy;

    assign busy = rd_q || wr_q;

    // transfer ends in the first cycle without waitrequest.
    assign done  = busy && !av_rsp.waitrequest;
    assign rdata = av_rsp.readdata; // valid alongside done.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else if (start) begin
            rd_q <= !write;
            wr_q <= write;
        end else if (done) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end
    end

    // held while waitrequest is high.
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    assign av_req.address   = addr_q;
    assign av_req.read      = rd_q;
    assign av_req.write     = wr_q;
    assign av_req.writedata = wdata_q;

endmodule

`default_nettype wire

// ==== verilog/mips_control.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_settings.svh"

module mips_control (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic                    active,
    output logic                    bus_start,
    output logic                    bus_write,
    output logic [31:0]             bus_addr,
    output logic [31:0]             bus_wdata,
    input  logic                    bus_done,
    input  logic [31:0]             bus_rdata,
    output logic [4:0]              rs_addr,
    output logic [4:0]              rt_addr,
    output logic [4:0]              wr_addr,
    output logic                    wr_en,
    output logic [31:0]             wr_data,
    input  logic [31:0]             rs_data,
    input  logic [31:0]             rt_data,
    output mips_isa_pkg::alu_ctrl_t alu_ctrl,
    output logic [31:0]             alu_a,
    output logic [31:0]             alu_b,
    output logic [15:0]             imm,
    input  logic [31:0]             alu_result
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_MEM,
        S_WB,
        S_HALT
    } state_e;

    state_e               state_q;
    logic [31:0]          pc_q;
    mips_isa_pkg::instr_u ir_q;
    logic [31:0]          a_q;
    logic [31:0]          b_q;
    logic [31:0]          res_q;
    logic [31:0]          mdr_q;
    logic                 is_jr;
    logic                 is_load;
    logic                 is_store;
    logic                 dest_we;
    logic [4:0]           dest;
    logic                 halt_jr;
    logic [31:0]          next_pc;

    // instruction decode.
    always_comb begin
        alu_ctrl.op       = mips_isa_pkg::ALU_ADD;
        alu_ctrl.use_imm  = 1'b1;
        alu_ctrl.sign_ext = 1'b1;
        is_jr             = 1'b0;
        is_load           = 1'b0;
        is_store          = 1'b0;
        dest_we           = 1'b0;
        dest              = ir_q.i.rt;
        case (ir_q.r.opcode)
            mips_isa_pkg::OP_SPECIAL: begin
                alu_ctrl.use_imm = 1'b0;
                dest             = ir_q.r.rd;
                dest_we          = 1'b1;
                case (ir_q.r.funct)
                    mips_isa_pkg::F_ADDU: alu_ctrl.op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::F_SUBU: alu_ctrl.op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::F_AND:  alu_ctrl.op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::F_OR:   alu_ctrl.op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::F_XOR:  alu_ctrl.op = mips_isa_pkg::ALU_XOR;
                    mips_isa_pkg::F_SLT:  alu_ctrl.op = mips_isa_pkg::ALU_SLT;
                    mips_isa_pkg::F_SLTU: alu_ctrl.op = mips_isa_pkg::ALU_SLTU;
                    mips_isa_pkg::F_JR: begin
                        is_jr   = 1'b1;
                        dest_we = 1'b0;
                    end
                    default: dest_we = 1'b0; // unsupported funct acts as nop.
                endcase
            end
            mips_isa_pkg::OP_ADDIU: dest_we = 1'b1;
            mips_isa_pkg::OP_ORI: begin
                alu_ctrl.op       = mips_isa_pkg::ALU_OR;
                alu_ctrl.sign_ext = 1'b0;
                dest_we           = 1'b1;
            end
            mips_isa_pkg::OP_LW: begin
                is_load = 1'b1;
                dest_we = 1'b1;
            end
            mips_isa_pkg::OP_SW: is_store = 1'b1;
            default: dest_we = 1'b0;
        endcase
    end

    assign halt_jr = is_jr && (a_q == `MIPS_HALT_PC);
    assign next_pc = is_jr ? a_q : pc_q;

    assign rs_addr = ir_q.r.rs;
    assign rt_addr = ir_q.r.rt;
    assign imm     = ir_q.i.imm;
    assign alu_a   = a_q;
    assign alu_b   = b_q;
    assign wr_addr = dest;
    assign wr_en   = (state_q == S_WB) && dest_we;
    assign wr_data = is_load ? mdr_q : res_q;

    // bus requests are issued one cycle before fetch and mem.
    always_comb begin
        bus_start = 1'b0;
        bus_write = 1'b0;
        bus_addr  = pc_q;
        bus_wdata = b_q; // rt value for sw.
        case (state_q)
            S_IDLE: bus_start = 1'b1;
            S_EXEC: begin
                bus_start = is_load || is_store;
                bus_write = is_store;
                bus_addr  = alu_result; // base plus offset.
            end
            S_WB: begin
                bus_start = !halt_jr;
                bus_addr  = next_pc;
            end
            default: bus_start = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= S_IDLE;
            active  <= 1'b0;
            pc_q    <= `MIPS_RESET_PC;
        end else begin
            case (state_q)
                S_IDLE: begin
                    active  <= 1'b1;
                    state_q <= S_FETCH;
                end
                S_FETCH: begin
                    if (bus_done) begin
                        pc_q    <= pc_q + 32'd4;
                        state_q <= S_DECODE;
                    end
                end
                S_DECODE: state_q <= S_EXEC;
                S_EXEC:   state_q <= (is_load || is_store) ? S_MEM : S_WB;
                S_MEM: begin
                    if (bus_done) begin
                        state_q <= S_WB;
                    end
                end
                S_WB: begin
                    pc_q <= next_pc;
                    if (halt_jr) begin
                        active  <= 1'b0;
                        state_q <= S_HALT;
                    end else begin
                        state_q <= S_FETCH;
                    end
                end
                default: state_q <= S_HALT; // parked until reset.
            endcase
        end
    end

    // datapath latches.
    always_ff @(posedge clk) begin
        if (state_q == S_FETCH && bus_done) begin
            ir_q <= bus_rdata;
        end
        if (state_q == S_DECODE) begin
            a_q <= rs_data;
            b_q <= rt_data;
        end
        if (state_q == S_EXEC) begin
            res_q <= alu_result;
        end
        if (state_q == S_MEM && bus_done) begin
            mdr_q <= bus_rdata; // load data for writeback.
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mips_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_top (
    input  logic                clk,
    input  logic                arst_n,
    output logic                active,
    output logic [31:0]         register_v0,
    output avalon_pkg::av_req_t av_req,
    input  avalon_pkg::av_rsp_t av_rsp
);

    logic                    bus_start;
    logic                    bus_write;
    logic [31:0]             bus_addr;
    logic [31:0]             bus_wdata;
    logic                    bus_done;
    logic [31:0]             bus_rdata;
    logic [4:0]              rs_addr;
    logic [4:0]              rt_addr;
    logic [4:0]              wr_addr;
    logic                    wr_en;
    logic [31:0]             wr_data;
    logic [31:0]             rs_data;
    logic [31:0]             rt_data;
    mips_isa_pkg::alu_ctrl_t alu_ctrl;
    logic [31:0]             alu_a;
    logic [31:0]             alu_b;
    logic [15:0]             imm;
    logic [31:0]             alu_result;

    mips_control u_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .active     (active),
        .bus_start  (bus_start),
        .bus_write  (bus_write),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_done   (bus_done),
        .bus_rdata  (bus_rdata),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .wr_addr    (wr_addr),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .alu_ctrl   (alu_ctrl),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .imm        (imm),
        .alu_result (alu_result)
    );

    mips_regfile u_regfile (
        .clk         (clk),
        .arst_n      (arst_n),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .wr_addr     (wr_addr),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    mips_alu u_alu (
        .ctrl   (alu_ctrl),
        .a      (alu_a),
        .b      (alu_b),
        .imm    (imm),
        .result (alu_result)
    );

    mips_bus_unit u_bus (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (bus_start),
        .write  (bus_write),
        .addr   (bus_addr),
        .wdata  (bus_wdata),
        .done   (bus_done),
        .rdata  (bus_rdata),
        .av_req (av_req),
        .av_rsp (av_rsp)
    );

endmodule

`default_nettype wire

// ==== dv/avalon_ram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module avalon_ram_model #(
    parameter int WORDS = 256
) (
    input  logic                clk,
    input  logic                stall,     // wait state request for this cycle.
    input  logic                load_en,
    input  logic [31:0]         load_addr, // byte address.
    input  logic [31:0]         load_data,
    input  avalon_pkg::av_req_t av_req,
    output avalon_pkg::av_rsp_t av_rsp
);

    localparam int AW = $clog2(WORDS);

    logic [31:0]   mem [WORDS];
    logic [AW-1:0] idx;
    logic          access;

    assign idx    = av_req.address[AW+1:2]; // word index.
    assign access = av_req.read || av_req.write;

    // background pattern differs at every address.
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] <= 32'hdead_0000 ^ (i << 2);
        end
    end

    assign av_rsp.waitrequest = access && stall;
    assign av_rsp.readdata    = mem[idx]; // valid whenever waitrequest is low.

    always @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[AW+1:2]] <= load_data; // program loader.
        end else if (av_req.write && !av_rsp.waitrequest) begin
            mem[idx] <= av_req.writedata;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_mips_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_settings.svh"

module tb_mips_cpu;

    typedef enum logic [1:0] {
        K_RTYPE, // two addiu operands, then one R-format op.
        K_ADDIU,
        K_ORI,
        K_MEM    // sw then lw at base plus offset.
    } kind_e;

    typedef struct packed {
        kind_e                kind;
        mips_isa_pkg::funct_e funct;
        logic [4:0]           rd;
        logic [15:0]          imm_a; // first operand or store base.
        logic [15:0]          imm_b; // second operand or store value.
        logic [15:0]          off;
        logic                 rnd;   // operands from the lfsr.
        logic                 waits;
    } test_row_t;

    localparam int NUM_ROWS     = 19;
    localparam int CYCLE_LIMIT  = NUM_ROWS * 300;
    localparam int RESET_CYCLES = 16;
    localparam int HALT_WATCH   = 12;

    localparam test_row_t ROWS [NUM_ROWS] = '{
        '{K_RTYPE, mips_isa_pkg::F_ADDU, 5'd2, 16'h1234, 16'h0567, 16'h0000, 1'b0, 1'b0},
        '{K_RTYPE, mips_isa_pkg::F_ADDU, 5'd2, 16'h1234, 16'h0567, 16'h0000, 1'b0, 1'b1},
        '{K_RTYPE, mips_isa_pkg::F_SUBU, 5'd2, 16'h0010, 16'h0020, 16'h0000, 1'b0, 1'b0},
        '{K_RTYPE, mips_isa_pkg::F_AND,  5'd5, 16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b0},
        '{K_RTYPE, mips_isa_pkg::F_OR,   5'd7, 16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b1},
        '{K_RTYPE, mips_isa_pkg::F_XOR,  5'd2, 16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b1},
        '{K_RTYPE, mips_isa_pkg::F_SLT,  5'd2, 16'hffff, 16'h0001, 16'h0000, 1'b0, 1'b0},
        '{K_RTYPE, mips_isa_pkg::F_SLTU, 5'd2, 16'hffff, 16'h0001, 16'h0000, 1'b0, 1'b0},
        '{K_RTYPE, mips_isa_pkg::F_SLT,  5'd3, 16'h0001, 16'hffff, 16'h0000, 1'b0, 1'b1},
        '{K_RTYPE, mips_isa_pkg::F_SLTU, 5'd3, 16'h0001, 16'hffff, 16'h0000, 1'b0, 1'b1},
        '{K_RTYPE, mips_isa_pkg::F_SLT,  5'd2, 16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b1},
        '{K_RTYPE, mips_isa_pkg::F_SLTU, 5'd2, 16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b1},
        '{K_RTYPE, mips_isa_pkg::F_ADDU, 5'd0, 16'h1111, 16'h2222, 16'h0000, 1'b0, 1'b0},
        '{K_ADDIU, mips_isa_pkg::F_ADDU, 5'd2, 16'h8000, 16'h0005, 16'h0000, 1'b0, 1'b0},
        '{K_ADDIU, mips_isa_pkg::F_ADDU, 5'd4, 16'h7fff, 16'h8001, 16'h0000, 1'b0, 1'b1},
        '{K_ORI,   mips_isa_pkg::F_ADDU, 5'd2, 16'h0000, 16'hf0f0, 16'h0000, 1'b0, 1'b0},
        '{K_ORI,   mips_isa_pkg::F_ADDU, 5'd6, 16'h0421, 16'h7a50, 16'h0000, 1'b0, 1'b1},
        '{K_MEM,   mips_isa_pkg::F_ADDU, 5'd2, 16'h0200, 16'hbeef, 16'hfff8, 1'b0, 1'b0},
        '{K_MEM,   mips_isa_pkg::F_ADDU, 5'd6, 16'h0180, 16'h0000, 16'h0010, 1'b1, 1'b1}
    };

    logic                clk;
    logic                arst_n;
    logic                stall;
    logic                waits_en;
    logic                load_en;
    logic [31:0]         load_addr;
    logic [31:0]         load_data;
    logic                active;
    logic [31:0]         register_v0;
    avalon_pkg::av_req_t av_req;
    avalon_pkg::av_rsp_t av_rsp;

    logic [15:0]         wait_lfsr;
    logic [15:0]         op_lfsr;
    logic [31:0]         prog [$];
    avalon_pkg::av_req_t prev_req;
    logic                prev_pending;
    logic                wr_seen;
    logic [31:0]         last_wr_addr;
    logic [31:0]         last_wr_data;
    int                  errors;
    int                  checks;
    int                  cycles;

    mips_cpu_top dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .active      (active),
        .register_v0 (register_v0),
        .av_req      (av_req),
        .av_rsp      (av_rsp)
    );

    avalon_ram_model mem0 (
        .clk       (clk),
        .stall     (stall),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .av_req    (av_req),
        .av_rsp    (av_rsp)
    );

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16, 14, 13, 11.
    endfunction

    task automatic take_random16(output logic [15:0] v);
        v = '0;
        for (int i = 0; i < 16; i++) begin
            op_lfsr = lfsr_step(op_lfsr);
            v = {v[14:0], op_lfsr[0]};
        end
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %08h, expected %08h", $time, what, actual,
                     expected);
        end
    endtask

    function automatic logic [31:0] encode_r(input logic [5:0] funct, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // result in rd is copied to $v0, then jr $zero halts.
    task automatic build_program(input test_row_t row, input logic [15:0] a,
                                 input logic [15:0] b);
        prog.delete();
        prog.push_back(encode_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, a));
        case (row.kind)
            K_RTYPE: begin
                prog.push_back(encode_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd9, b));
                prog.push_back(encode_r(row.funct, 5'd8, 5'd9, row.rd));
            end
            K_ADDIU: prog.push_back(encode_i(mips_isa_pkg::OP_ADDIU, 5'd8, row.rd, b));
            K_ORI:   prog.push_back(encode_i(mips_isa_pkg::OP_ORI, 5'd8, row.rd, b));
            default: begin
                prog.push_back(encode_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd9, b));
                prog.push_back(encode_i(mips_isa_pkg::OP_SW, 5'd8, 5'd9, row.off));
                prog.push_back(encode_i(mips_isa_pkg::OP_LW, 5'd8, row.rd, row.off));
            end
        endcase
        prog.push_back(encode_r(mips_isa_pkg::F_ADDU, row.rd, 5'd0, 5'd2));
        prog.push_back(encode_r(mips_isa_pkg::F_JR, 5'd0, 5'd0, 5'd0));
    endtask

    function automatic logic [31:0] expected_v0(input test_row_t row, input logic [15:0] a,
                                                input logic [15:0] b);
        logic [31:0] sa;
        logic [31:0] sb;
        logic [31:0] r;
        sa = {{16{a[15]}}, a};
        sb = {{16{b[15]}}, b};
        case (row.kind)
            K_RTYPE: begin
                case (row.funct)
                    mips_isa_pkg::F_ADDU: r = sa + sb;
                    mips_isa_pkg::F_SUBU: r = sa - sb;
                    mips_isa_pkg::F_AND:  r = sa & sb;
                    mips_isa_pkg::F_OR:   r = sa | sb;
                    mips_isa_pkg::F_XOR:  r = sa ^ sb;
                    mips_isa_pkg::F_SLT:  r = {31'd0, $signed(sa) < $signed(sb)};
                    mips_isa_pkg::F_SLTU: r = {31'd0, sa < sb};
                    default:              r = 32'd0;
                endcase
            end
            K_ADDIU: r = sa + sb;
            K_ORI:   r = sa | {16'd0, b}; // ori zero extends.
            default: r = sb;              // value stored then loaded back.
        endcase
        return (row.rd == 5'd0) ? 32'd0 : r;
    endfunction

    task automatic run_row(input test_row_t row);
        logic [15:0] a;
        logic [15:0] b;
        logic [31:0] exp_v0;
        logic [31:0] exp_addr;
        a = row.imm_a;
        b = row.imm_b;
        if (row.rnd) begin
            if (row.kind != K_MEM) begin
                take_random16(a);
            end
            take_random16(b);
        end
        build_program(row, a, b);
        exp_v0   = expected_v0(row, a, b);
        exp_addr = {{16{a[15]}}, a} + {{16{row.off[15]}}, row.off};
        for (int n = 0; n < RESET_CYCLES; n++) begin
            @(posedge clk);
            arst_n    <= 1'b0;
            waits_en  <= row.waits;
            wr_seen   = 1'b0;
            load_addr <= `MIPS_RESET_PC + 32'(4 * n);
            if (n < prog.size()) begin
                load_en   <= 1'b1;
                load_data <= prog[n];
            end else begin
                load_en   <= 1'b0;
                load_data <= 32'd0;
            end
        end
        @(posedge clk);
        arst_n  <= 1'b1;
        load_en <= 1'b0;
        do @(negedge clk); while (!active);
        do @(negedge clk); while (active);
        // halted core keeps the bus quiet.
        for (int n = 0; n < HALT_WATCH; n++) begin
            @(negedge clk);
            check_equal({31'd0, active}, 32'd0, "active after halt");
            check_equal({30'd0, av_req.read, av_req.write}, 32'd0, "bus access after halt");
        end
        check_equal(register_v0, exp_v0, "register_v0");
        if (row.kind == K_MEM) begin
            check_equal({31'd0, wr_seen}, 32'd1, "store seen on bus");
            check_equal(last_wr_addr, exp_addr, "store address");
            check_equal(last_wr_data, {{16{b[15]}}, b}, "store data");
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
    endtask

    // one lfsr bit per cycle decides a wait state.
    always @(posedge clk) begin
        wait_lfsr = lfsr_step(wait_lfsr);
        stall <= waits_en && wait_lfsr[0];
    end

    // bus protocol monitor.
    always @(negedge clk) begin
        if (arst_n) begin
            check_equal({31'd0, av_req.read && av_req.write}, 32'd0, "read and write together");
            if (prev_pending) begin
                check_equal({31'd0, av_req != prev_req}, 32'd0, "request moved in waitrequest");
            end
            if (av_req.write && !av_rsp.waitrequest) begin
                wr_seen      = 1'b1;
                last_wr_addr = av_req.address;
                last_wr_data = av_req.writedata;
            end
            prev_pending = (av_req.read || av_req.write) && av_rsp.waitrequest;
            prev_req     = av_req;
        end else begin
            prev_pending = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            $display("ERROR: cycle limit of %0d reached before the tests finished", CYCLE_LIMIT);
            print_summary();
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        stall        = 1'b0;
        waits_en     = 1'b0;
        load_en      = 1'b0;
        load_addr    = 32'd0;
        load_data    = 32'd0;
        wait_lfsr    = 16'd65;
        op_lfsr      = 16'd65;
        prev_req     = '0;
        prev_pending = 1'b0;
        wr_seen      = 1'b0;
        last_wr_addr = 32'd0;
        last_wr_data = 32'd0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(ROWS[r]);
        end
        print_summary();
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verilog
verilog/mips_isa_pkg.sv
verilog/avalon_pkg.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_bus_unit.sv
verilog/mips_control.sv
verilog/mips_cpu_top.sv
dv/avalon_ram_model.sv
dv/tb_mips_cpu.sv

// ==== Makefile ====
# Verilator build and run for the MIPS core testbench.

VERILATOR ?= verilator
TOP       ?= tb_mips_cpu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= tb.f

SOURCES := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
